// File: countdownTimer.f
verilog/timerPkg.sv
verilog/PrefixAnd.sv
verilog/DecC.sv
verilog/timerRegs.sv
verilog/timerCore.sv
verilog/countdownTimer.sv
dv/countdownTimer_properties.sv
dv/countdownTimerTb.sv

// File: Bender.yml
package:
  name: countdownTimer

sources:
  - verilog/timerPkg.sv
  - verilog/PrefixAnd.sv
  - verilog/DecC.sv
  - verilog/timerRegs.sv
  - verilog/timerCore.sv
  - verilog/countdownTimer.sv
  - target: test
    files:
      - dv/countdownTimer_properties.sv
      - dv/countdownTimerTb.sv

// File: dv/countdownTimerTb.sv
`timescale 1ns/1ps
`default_nettype none

module countdownTimerTb;

	localparam int cw = timerPkg::counterWidth;
	localparam int nc = timerPkg::numChannels;
	localparam int maxCycles = 2 * (20 + 40 + 120 + 80 + 400 * 7); // twice the test lengths

	logic                  clk;
	logic                  arstN;
	logic                  wrStrobe;
	timerPkg::regWrite_t   wrReq;
	logic [nc-1:0][cw-1:0] count;
	logic [nc-1:0]         expire;

	timerPkg::timerCfg_t   mCfg;    // model register block
	timerPkg::chanCmd_t    mCmd;
	logic [cw-1:0]         mPre;    // model prescaler
	logic                  mTick;
	logic [nc-1:0][cw-1:0] mCount;
	logic [nc-1:0]         mRun;    // model channel running
	logic [nc-1:0]         mExpire;

	int seed = 64;
	int cycle = 0;
	int errors = 0;
	int checks = 0;
	int testErrors = 0;
	int pulses [nc] = '{default: 0}; // expire pulses seen per channel
	int t0, t1, t2;
	logic [cw-1:0] frozen;
	logic [cw-1:0] wData;
	logic [31:0]   r;

	countdownTimer u_countdownTimer (
		.clk(clk), .arstN(arstN), .wrStrobe(wrStrobe),
		.wrReq(wrReq), .count(count), .expire(expire)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk; // 100 ns period
	end

	always @(posedge clk) begin
		cycle <= cycle + 1;
		if (cycle >= maxCycles) begin
			$display("timeout, run stopped after %0d cycles", cycle);
			$display("TB FAILED");
			$finish;
		end
	end

	// cycle model stepping the core on the old settings before the registers update
	always @(posedge clk) begin
		if (!arstN) begin
			mCfg = '0;
			mCmd = '0;
			mPre = '0;
			mCount = '0;
			mRun = '0;
			mExpire = '0;
		end else begin
			mTick = (mPre == '0);
			mPre = mTick ? mCfg.prescale : mPre - 1'b1; // period prescale+1
			mExpire = '0;
			for (int c = 0; c < nc; c++) begin
				if (mCmd.load[c] || mCmd.start[c] || mCmd.stop[c]) begin
					if (mCmd.load[c]) mCount[c] = mCfg.reload[c];
					mRun[c] = (mRun[c] || mCmd.start[c]) && !mCmd.stop[c]; // stop wins
				end else if (mTick && mRun[c] && mCount[c] == '0) begin
					mExpire[c] = 1'b1;
					if (mCfg.autoReload[c]) mCount[c] = mCfg.reload[c];
					else mRun[c] = 1'b0; // one-shot rests at zero
				end else if (mTick && mRun[c]) begin
					mCount[c] = mCount[c] - 1'b1;
				end
			end
			mCmd = '0;
			if (wrStrobe) begin
				case (wrReq.addr)
					timerPkg::addrPrescale: mCfg.prescale = wrReq.data;
					timerPkg::addrReload0: begin
						mCfg.reload[0] = wrReq.data;
						mCmd.load[0] = 1'b1;
					end
					timerPkg::addrReload1: begin
						mCfg.reload[1] = wrReq.data;
						mCmd.load[1] = 1'b1;
					end
					default: begin // control word
						mCfg.autoReload = wrReq.data[nc-1:0];
						mCmd.start = wrReq.data[4 +: nc];
						mCmd.stop = wrReq.data[8 +: nc];
					end
				endcase
			end
		end
	end

	// a pulse is counted on the edge that ends its cycle
	always @(posedge clk) begin
		if (arstN) begin
			for (int c = 0; c < nc; c++)
				if (expire[c]) pulses[c]++;
		end
	end

	// outputs settle before the falling edge
	always @(negedge clk) begin
		if (arstN) begin
			checks = checks + 2;
			if (count !== mCount) begin
				errors++;
				$display("Error at %0t: count expected %h, got %h", $time, mCount, count);
			end
			if (expire !== mExpire) begin
				errors++;
				$display("Error at %0t: expire expected %b, got %b", $time, mExpire, expire);
			end
		end
	end

	task automatic writeReg(input timerPkg::regAddr_e a, input logic [cw-1:0] d);
		@(posedge clk);
		wrStrobe <= 1'b1;
		wrReq <= '{addr: a, data: d};
		@(posedge clk);
		wrStrobe <= 1'b0; // single-cycle strobe
	endtask

	function automatic logic [cw-1:0] ctrlWord(input logic [nc-1:0] autoRl, start, stop);
		logic [cw-1:0] w;
		w = '0;
		w[nc-1:0] = autoRl;
		w[4 +: nc] = start;
		w[8 +: nc] = stop;
		return w;
	endfunction

	// returns the cycle of the next expire on ch or -1 when none came
	task automatic waitExpire(input int ch, input int limit, output int at);
		at = -1;
		for (int n = 0; n < limit && at < 0; n++) begin
			@(negedge clk);
			if (expire[ch]) at = cycle;
		end
		if (at < 0) begin
			errors++;
			$display("expire[%0d] did not pulse within %0d cycles", ch, limit);
		end
	endtask

	task automatic finishTest(input int n, input string name);
		@(posedge clk); // checks of the last falling edge land first
		$display("test %0d (%s) finished with %0d errors", n, name, errors - testErrors);
		testErrors = errors;
	endtask

	initial begin
		wrStrobe = 1'b0;
		wrReq = '0;
		arstN = 1'b0;
		repeat (5) @(posedge clk);
		arstN <= 1'b1;
		repeat (20) @(negedge clk); // quiet after reset
		if (count !== '0) begin
			errors++;
			$display("Error at %0t: count expected 0, got %h", $time, count);
		end
		if (pulses[0] + pulses[1] != 0) begin
			errors++;
			$display("expire pulsed with no writes after reset");
		end
		finishTest(1, "reset");
		writeReg(timerPkg::addrReload0, 16'd10); // prescale still zero
		writeReg(timerPkg::addrCtrl, ctrlWord(2'b00, 2'b01, 2'b00));
		@(negedge clk);
		t0 = cycle;
		waitExpire(0, 40, t1);
		if (t1 - t0 != 12) begin // one cycle to start plus R+1 ticks
			errors++;
			$display("Error at %0t: expire[0] delay expected 12, got %0d", $time, t1 - t0);
		end
		t0 = pulses[0]; // the pulse just seen is counted on the next edge
		repeat (20) @(negedge clk);
		if (count[0] !== '0) begin
			errors++;
			$display("Error at %0t: count[0] expected 0, got %0d", $time, count[0]);
		end
		if (pulses[0] != t0 + 1) begin
			errors++;
			$display("channel 0 expired again after its one-shot");
		end
		finishTest(2, "one-shot");
		writeReg(timerPkg::addrPrescale, 16'd3);
		writeReg(timerPkg::addrReload1, 16'd4);
		writeReg(timerPkg::addrCtrl, ctrlWord(2'b10, 2'b10, 2'b00));
		waitExpire(1, 60, t0);
		waitExpire(1, 60, t1);
		waitExpire(1, 60, t2);
		if (t1 - t0 != 20 || t2 - t1 != 20) begin // (R+1)(P+1)
			errors++;
			$display("Error at %0t: expire[1] period expected 20, got %0d and %0d",
				$time, t1 - t0, t2 - t1);
		end
		writeReg(timerPkg::addrCtrl, ctrlWord(2'b00, 2'b00, 2'b10));
		finishTest(3, "prescale");
		writeReg(timerPkg::addrReload0, 16'd30);
		writeReg(timerPkg::addrCtrl, ctrlWord(2'b00, 2'b01, 2'b00));
		repeat (40) @(negedge clk);
		writeReg(timerPkg::addrCtrl, ctrlWord(2'b00, 2'b00, 2'b01)); // stop mid-count
		repeat (2) @(negedge clk);
		frozen = count[0];
		t0 = pulses[0];
		repeat (30) @(negedge clk);
		if (count[0] !== frozen) begin
			errors++;
			$display("Error at %0t: count[0] expected %0d, got %0d", $time, frozen, count[0]);
		end
		if (pulses[0] != t0) begin
			errors++;
			$display("expire[0] pulsed while channel 0 was stopped");
		end
		writeReg(timerPkg::addrCtrl, ctrlWord(2'b00, 2'b01, 2'b00)); // resume without a load
		waitExpire(0, (frozen + 2) * 4 + 10, t1);
		finishTest(4, "stop");
		for (int i = 0; i < 400; i++) begin
			r = $random(seed);
			if (r[17:16] == 2'd3) begin
				wData = ctrlWord(r[1:0], r[3:2], r[5:4] & r[7:6]); // start and stop may collide
			end else begin
				wData = (r[17:16] == 2'd0) ? r[1:0] : r[5:0]; // short periods give many expires
			end
			writeReg(timerPkg::regAddr_e'(r[17:16]), wData);
			repeat (r[20:18] % 4) @(posedge clk);
		end
		repeat (50) @(negedge clk);
		finishTest(5, "random");
		if (u_countdownTimer.u_timerCore.u_props.assertFails != 0) begin
			errors = errors + u_countdownTimer.u_timerCore.u_props.assertFails;
			$display("%0d assertions on the core failed",
				u_countdownTimer.u_timerCore.u_props.assertFails);
		end
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: dv/countdownTimer_properties.sv
`timescale 1ns/1ps
`default_nettype none

module countdownTimer_properties (
	input logic                                clk,
	input logic                                arstN,
	input timerPkg::timerCfg_t                 cfg,
	input timerPkg::chanCmd_t                  cmd,
	input logic                                tick,
	input timerPkg::chanState_e                state [timerPkg::numChannels],
	input logic [timerPkg::numChannels-1:0][timerPkg::counterWidth-1:0] count,
	input logic [timerPkg::numChannels-1:0]    expire
);

	int assertFails = 0; // failed assertion count

	for (genvar c = 0; c < timerPkg::numChannels; c++) begin : chanProps
		// nonzero prescale spaces ticks at least two cycles apart
		noBackToBack: assert property (@(posedge clk) disable iff (!arstN)
			expire[c] && cfg.prescale != '0 && $past(cfg.prescale) != '0 |=> !expire[c])
			else begin
				$error("expire[%0d] high on two cycles in a row", c);
				assertFails++;
			end
		expireFromRun: assert property (@(posedge clk) disable iff (!arstN)
			expire[c] |-> $past(state[c] == timerPkg::chRunning))
			else begin
				$error("expire[%0d] without a running channel before it", c);
				assertFails++;
			end
		holdCount: assert property (@(posedge clk) disable iff (!arstN)
			!tick && !cmd.load[c] && !cmd.start[c] && !cmd.stop[c] |=> $stable(count[c]))
			else begin
				$error("count[%0d] moved with no tick and no command", c);
				assertFails++;
			end
	end

endmodule

bind timerCore countdownTimer_properties u_props (
	.clk(clk), .arstN(arstN), .cfg(cfg), .cmd(cmd),
	.tick(tick), .state(state), .count(count), .expire(expire)
);

`default_nettype wire

// File: verilog/countdownTimer.sv
`timescale 1ns/1ps
`default_nettype none

module countdownTimer (
	input  logic                                clk,
	input  logic                                arstN,
	input  logic                                wrStrobe, // no back-pressure
	input  timerPkg::regWrite_t                 wrReq,
	output logic [timerPkg::numChannels-1:0][timerPkg::counterWidth-1:0] count,
	output logic [timerPkg::numChannels-1:0]    expire
);

	timerPkg::timerCfg_t cfg; // stored settings
	timerPkg::chanCmd_t  cmd; // registered strobes

	timerRegs u_timerRegs (
		.clk     (clk),
		.arstN   (arstN),
		.wrStrobe(wrStrobe),
		.wrReq   (wrReq),
		.cfg     (cfg),
		.cmd     (cmd)
	);

	// two cycles from write strobe to count
	timerCore u_timerCore (
		.clk   (clk),
		.arstN (arstN),
		.cfg   (cfg),
		.cmd   (cmd),
		.count (count),
		.expire(expire)
	);

endmodule

`default_nettype wire

// File: verilog/timerCore.sv
`timescale 1ns/1ps
`default_nettype none

module timerCore (
	input  logic                                clk,
	input  logic                                arstN,
	input  timerPkg::timerCfg_t                 cfg,
	input  timerPkg::chanCmd_t                  cmd,
	output logic [timerPkg::numChannels-1:0][timerPkg::counterWidth-1:0] count,
	output logic [timerPkg::numChannels-1:0]    expire // one-cycle pulse
);

	logic [timerPkg::counterWidth-1:0] preCnt;  // prescaler counter
	logic [timerPkg::counterWidth-1:0] preNext;
	logic                              tick;    // prescaler hit zero

	timerPkg::chanState_e              state [timerPkg::numChannels];
	logic [timerPkg::counterWidth-1:0] decZ  [timerPkg::numChannels];
	logic [timerPkg::numChannels-1:0]  decEn;   // tick on a running channel
	logic [timerPkg::numChannels-1:0]  borrow;  // tick found count at zero

	// prescaler always counts, borrow doubles as zero detect
	DecC #(
		.width(timerPkg::counterWidth),
		.speed(timerPkg::decSpeed)
	) u_preDec (
		.A (preCnt),
		.CI(1'b1),
		.Z (preNext),
		.CO(tick)
	);

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			preCnt <= '0;
		end else begin
			preCnt <= tick ? cfg.prescale : preNext; // period prescale+1
		end
	end

	for (genvar c = 0; c < timerPkg::numChannels; c++) begin : chanDec
		assign decEn[c] = tick && (state[c] == timerPkg::chRunning);

		DecC #(
			.width(timerPkg::counterWidth),
			.speed(timerPkg::decSpeed)
		) u_chanDec (
			.A (count[c]),
			.CI(decEn[c]),
			.Z (decZ[c]),
			.CO(borrow[c])
		);
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			count  <= '0;
			expire <= '0;
			for (int c = 0; c < timerPkg::numChannels; c++) begin
				state[c] <= timerPkg::chIdle;
			end
		end else begin
			expire <= '0;
			for (int c = 0; c < timerPkg::numChannels; c++) begin
				if (cmd.load[c] || cmd.start[c] || cmd.stop[c]) begin
					// commands override a tick in the same cycle
					if (cmd.load[c]) count[c] <= cfg.reload[c];
					if (cmd.start[c]) state[c] <= timerPkg::chRunning;
					if (cmd.stop[c]) state[c] <= timerPkg::chIdle; // stop beats start
				end else if (borrow[c]) begin
					expire[c] <= 1'b1;
					if (cfg.autoReload[c]) begin
						count[c] <= cfg.reload[c]; // next period
					end else begin
						state[c] <= timerPkg::chIdle; // one-shot, count rests at zero
					end
				end else if (decEn[c]) begin
					count[c] <= decZ[c];
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: verilog/timerRegs.sv
`timescale 1ns/1ps
`default_nettype none

module timerRegs (
	input  logic                 clk,
	input  logic                 arstN,
	input  logic                 wrStrobe, // qualifies wrReq
	input  timerPkg::regWrite_t  wrReq,
	output timerPkg::timerCfg_t  cfg,      // stable between writes
	output timerPkg::chanCmd_t   cmd       // one-cycle strobes
);

	logic [timerPkg::counterWidth-1:0] wrData;
	logic [timerPkg::numChannels-1:0]  ctrlStart;
	logic [timerPkg::numChannels-1:0]  ctrlStop;

	assign wrData = wrReq.data;

	// control word fields
	assign ctrlStart = wrData[timerPkg::ctrlStartBit +: timerPkg::numChannels];
	assign ctrlStop  = wrData[timerPkg::ctrlStopBit +: timerPkg::numChannels];

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			cfg <= '0;
			cmd <= '0;
		end else begin
			cmd <= '0; // strobes drop after one cycle
			if (wrStrobe) begin
				unique case (wrReq.addr)
					timerPkg::addrPrescale: begin
						cfg.prescale <= wrData;
					end
					timerPkg::addrReload0: begin
						cfg.reload[0] <= wrData;
						cmd.load[0]   <= 1'b1; // copy into count next cycle
					end
					timerPkg::addrReload1: begin
						cfg.reload[1] <= wrData;
						cmd.load[1]   <= 1'b1;
					end
					timerPkg::addrCtrl: begin
						// mode bits stored together with the strobes
						cfg.autoReload <= wrData[timerPkg::numChannels-1:0];
						cmd.start      <= ctrlStart;
						cmd.stop       <= ctrlStop;
					end
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// File: verilog/DecC.sv
`timescale 1ns/1ps
`default_nettype none

// {CO,Z} = A - CI, lookahead on the inverted operand
module DecC #(
	parameter int width = 8, // word width
	parameter int speed = 1  // prefix structure, see PrefixAnd
) (
	input  logic [width-1:0] A,  // operand
	input  logic             CI, // borrow in
	output logic [width-1:0] Z,  // difference
	output logic             CO  // borrow out, A zero and CI set
);

	logic [width:0] zeroRun; // CI and all lower bits of A zero
	logic [width:0] propIn;

	assign propIn = {~A, CI}; // bit 0 carries CI

	PrefixAnd #(
		.width(width + 1),
		.speed(speed)
	) u_prefix (
		.PI(propIn),
		.PO(zeroRun)
	);

	assign Z  = A ^ zeroRun[width-1:0]; // flip where borrow ripples in
	assign CO = zeroRun[width];

endmodule

`default_nettype wire

// File: verilog/PrefixAnd.sv
`timescale 1ns/1ps
`default_nettype none

module PrefixAnd #(
	parameter int width = 8, // word width
	parameter int speed = 1  // 0 serial, 1 brent-kung, 2 sklansky
) (
	input  logic [width-1:0] PI, // propagate in
	output logic [width-1:0] PO  // prefix and of PI[i:0]
);

	localparam int n = width;
	localparam int m = $clog2(width); // tree depth

	if (speed == 2) begin : fastPrefix
		// sklansky, depth m, fanout grows per level
		logic [m:0][n-1:0] pt;

		assign pt[0] = PI;
		for (genvar l = 1; l <= m; l++) begin : levels
			for (genvar i = 0; i < n; i++) begin : bits
				// last bit of the lower half in this group
				localparam int partner = (i / 2**l) * 2**l + 2**(l-1) - 1;
				if ((i / 2**(l-1)) % 2 == 1) begin : black
					assign pt[l][i] = pt[l-1][i] & pt[l-1][partner];
				end else begin : white
					assign pt[l][i] = pt[l-1][i];
				end
			end
		end
		assign PO = pt[m];
	end else if (speed == 1) begin : mediumPrefix
		// brent-kung, up-sweep then down-sweep
		logic [2*m-1:0][n-1:0] pt;

		assign pt[0] = PI;
		for (genvar l = 1; l <= m; l++) begin : upLevels
			for (genvar i = 0; i < n; i++) begin : bits
				if ((i + 1) % 2**l == 0) begin : black
					assign pt[l][i] = pt[l-1][i] & pt[l-1][i - 2**(l-1)];
				end else begin : white
					assign pt[l][i] = pt[l-1][i];
				end
			end
		end
		for (genvar l = m + 1; l <= 2*m - 1; l++) begin : downLevels
			localparam int span = 2**(2*m - 1 - l); // halves every level
			for (genvar i = 0; i < n; i++) begin : bits
				if (i >= 2*span && (i + 1) % (2*span) == span) begin : black
					assign pt[l][i] = pt[l-1][i] & pt[l-1][i - span];
				end else begin : white
					assign pt[l][i] = pt[l-1][i];
				end
			end
		end
		assign PO = pt[2*m-1];
	end else begin : slowPrefix
		// ripple chain, smallest area
		logic [n-1:0] pt;

		assign pt[0] = PI[0];
		for (genvar i = 1; i < n; i++) begin : bits
			assign pt[i] = pt[i-1] & PI[i];
		end
		assign PO = pt;
	end

endmodule

`default_nettype wire

// File: verilog/timerPkg.sv
`default_nettype none

package timerPkg;

	localparam int counterWidth = 16; // prescaler, reload and count width
	localparam int numChannels  = 2;
	localparam int decSpeed     = 1;  // 0 serial, 1 brent-kung, 2 sklansky

	// control word layout, autoReload sits at bit c
	localparam int ctrlStartBit = 4;
	localparam int ctrlStopBit  = 8;

	// write address, doubles as the opcode of a write
	typedef enum logic [1:0] {
		addrPrescale = 2'd0,
		addrReload0  = 2'd1,
		addrReload1  = 2'd2,
		addrCtrl     = 2'd3
	} regAddr_e;

	typedef enum logic {
		chIdle    = 1'b0,
		chRunning = 1'b1
	} chanState_e;

	typedef struct packed {
		regAddr_e                addr;
		logic [counterWidth-1:0] data;
	} regWrite_t;

	typedef struct packed {
		logic [counterWidth-1:0]                  prescale;
		logic [numChannels-1:0][counterWidth-1:0] reload;
		logic [numChannels-1:0]                   autoReload;
	} timerCfg_t;

	// one-cycle strobes, one bit per channel
	typedef struct packed {
		logic [numChannels-1:0] load;
		logic [numChannels-1:0] start;
		logic [numChannels-1:0] stop;
	} chanCmd_t;

endpackage

`default_nettype wire
